// ==== Bender.yml ====
package:
  name: ce_rx

sources:
  - ce_rx_pkg.sv
  - ce_rx_ingress.sv
  - ce_rx_fsm.sv
  - ce_rx_realign.sv
  - ce_cpl_fifo.sv
  - ce_rx_top.sv
  - target: test
    files:
      - ce_rx_assert.sv
      - tb_ce_rx.sv

// ==== ce_cpl_fifo.sv ====
// --------------------
// Register-array FIFO for realigned completion words
// Read data shows the head entry whenever not empty
// Pushes when full and pops when empty are ignored
// --------------------

`timescale 1ns/100ps

module ce_cpl_fifo import ce_rx_pkg::*; (
   input  logic                      clk,
   input  logic                      ce_corereset,
   input  logic                      cpl_wen,
   input  logic [CE_CPL_ENTRY_W-1:0] cpl_wdata,
   input  logic                      cpl_rd_en,
   output logic [CE_CPL_ENTRY_W-1:0] cpl_rd_data,
   output logic                      cpl_empty,
   output logic                      fifo_full,
   output logic                      fifo_almost_full
);

   logic [CE_CPL_ENTRY_W-1:0] mem [CE_FIFO_DEPTH];
   logic [CE_FIFO_AW-1:0]     wr_ptr;
   logic [CE_FIFO_AW-1:0]     rd_ptr;
   logic [CE_FIFO_CNT_W-1:0]  count;
   logic                      push;
   logic                      pop;

   assign push = cpl_wen & ~fifo_full;
   assign pop  = cpl_rd_en & ~cpl_empty;

   // --------------------
   // Storage
   // --------------------
   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= cpl_wdata;
      end
   end

   assign cpl_rd_data = mem[rd_ptr];

   // Pointers wrap at the power-of-two depth
   always_ff @(posedge clk) begin
      if (ce_corereset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

   // --------------------
   // Occupancy
   // --------------------
   always_ff @(posedge clk) begin
      if (ce_corereset) begin
         count <= '0;
      end else if (push && !pop) begin
         count <= count + 1'b1;
      end else if (pop && !push) begin
         count <= count - 1'b1;
      end
   end

   assign cpl_empty        = (count == '0);
   assign fifo_full        = (count == CE_FIFO_CNT_W'(CE_FIFO_DEPTH));
   // Drives receive ready low
   assign fifo_almost_full = (count >= CE_FIFO_CNT_W'(CE_FIFO_AF_LEVEL));

endmodule

// ==== ce_rx_assert.sv ====
// --------------------
// Concurrent checks on the receive top level, bound at the end of this file
// Reset disables all but the sticky error check
// --------------------

`timescale 1ns/100ps

module ce_rx_assert (
   input logic clk,
   input logic ce_corereset,
   input logic rx_tready,
   input logic fifo_almost_full,
   input logic fifo_full,
   input logic cpl_wen,
   input logic wr_active,
   input logic cpl_err
);

   // Back-pressure follows the FIFO level
   assert property (@(posedge clk) disable iff (ce_corereset) fifo_almost_full |-> !rx_tready)
      else $error("rx_tready high while the FIFO is almost full");

   // Margin keeps pushes off a full FIFO
   assert property (@(posedge clk) disable iff (ce_corereset) !(cpl_wen && fifo_full))
      else $error("FIFO write while full");

   // Writes only in the write state
   assert property (@(posedge clk) disable iff (ce_corereset) cpl_wen |-> wr_active)
      else $error("FIFO write in RX_IDLE");

   // Sticky error falls only after reset
   assert property (@(posedge clk) $fell(cpl_err) |-> $past(ce_corereset))
      else $error("cpl_err cleared without reset");

endmodule

bind ce_rx_top ce_rx_assert i_ce_rx_assert (
   .clk, .ce_corereset, .rx_tready, .fifo_almost_full,
   .fifo_full, .cpl_wen, .wr_active, .cpl_err
);

// ==== ce_rx_fsm.sv ====
// --------------------
// Two-state receive FSM, wr_active opens the FIFO write path
// Error pulses win over every other transition
// --------------------

`timescale 1ns/100ps

module ce_rx_fsm import ce_rx_pkg::*; (
   input  logic clk,
   input  logic ce_corereset,
   input  logic hdr_start,
   input  logic hdr_ok,
   input  logic hdr_err,
   input  logic beat_last,
   input  logic tail_pending,
   input  logic wr_resp_err,
   input  logic fifo_err,
   input  logic cpl_err,
   output logic wr_active
);

   ce_rx_state_e state;
   ce_rx_state_e state_nxt;
   logic         restart;

   // Good completion header with no error holding the engine off
   assign restart = hdr_start & hdr_ok & ~cpl_err & ~fifo_err;

   always_ff @(posedge clk) begin
      if (ce_corereset) begin
         state <= RX_IDLE;
      end else begin
         state <= state_nxt;
      end
   end

   always_comb begin
      state_nxt = state;
      if (wr_resp_err || hdr_err) begin
         // Abort, rest of the packet is dropped
         state_nxt = RX_IDLE;
      end else begin
         case (state)
            RX_IDLE: begin
               if (restart) begin
                  state_nxt = RX_CPL_WR;
               end
            end
            RX_CPL_WR: begin
               if (tail_pending) begin
                  // Flush cycle, stay only for a back-to-back header
                  state_nxt = restart ? RX_CPL_WR : RX_IDLE;
               end else if (beat_last) begin
                  // Flush word still owed next cycle
                  state_nxt = RX_CPL_WR;
               end
            end
            default: state_nxt = RX_IDLE;
         endcase
      end
   end

   assign wr_active = (state == RX_CPL_WR);

endmodule

// ==== ce_rx_ingress.sv ====
// --------------------
// Samples the receive bus and decodes completion headers
// Ready drops combinationally on FIFO almost-full, beats in flight still land
// Decode strobes are valid only in the header beat's registered cycle
// --------------------

`timescale 1ns/100ps

module ce_rx_ingress import ce_rx_pkg::*; (
   input  logic                   clk,
   input  logic                   ce_corereset,
   input  logic                   rx_tvalid,
   input  logic [CE_DATA_W-1:0]   rx_tdata,
   input  logic [CE_KEEP_W-1:0]   rx_tkeep,
   input  logic                   rx_tlast,
   input  logic                   mrd_start,
   input  logic                   fifo_almost_full,
   output logic                   rx_tready,
   output logic                   beat_valid,
   output logic [CE_DATA_W-1:0]   beat_data,
   output logic [CE_KEEP_W-1:0]   beat_keep,
   output logic                   beat_last,
   output logic                   hdr_start,
   output logic                   hdr_ok,
   output logic                   hdr_err,
   output logic                   hdr_fc,
   output logic [CE_STATUS_W-1:0] cpl_status,
   output logic                   cpl_err
);

   logic                   in_pkt;
   logic                   hdr_beat;
   ce_fmt_e                hdr_fmt;
   logic [CE_STATUS_W-1:0] hdr_status;
   logic                   status_good;

   // --------------------
   // Input sampling
   // --------------------

   // Back-pressure only on FIFO level
   assign rx_tready = ~fifo_almost_full;

   // Control bits of the accepted beat
   always_ff @(posedge clk) begin
      if (ce_corereset) begin
         beat_valid <= 1'b0;
         beat_last  <= 1'b0;
      end else begin
         beat_valid <= rx_tvalid & rx_tready;
         // Last is qualified so later stages can use it alone
         beat_last  <= rx_tvalid & rx_tready & rx_tlast;
      end
   end

   // Payload follows the bus every cycle
   always_ff @(posedge clk) begin
      beat_data <= rx_tdata;
      beat_keep <= rx_tkeep;
   end

   // --------------------
   // Header beat detection
   // --------------------

   // High once a packet's first beat has gone by
   always_ff @(posedge clk) begin
      if (ce_corereset) begin
         in_pkt <= 1'b0;
      end else if (beat_last) begin
         in_pkt <= 1'b0;
      end else if (beat_valid) begin
         in_pkt <= 1'b1;
      end
   end

   assign hdr_beat = beat_valid & ~in_pkt;

   // Header fields from the low half
   assign hdr_fmt     = ce_fmt_e'(beat_data[HDR_FMT_LSB +: HDR_FMT_W]);
   assign hdr_status  = beat_data[HDR_STATUS_LSB +: CE_STATUS_W];
   assign status_good = (hdr_status == '0);

   // Only DM completions during an active read count
   assign hdr_start = hdr_beat & (hdr_fmt == FMT_DM_CPL) & mrd_start;
   assign hdr_ok    = hdr_start & status_good;
   assign hdr_err   = hdr_start & ~status_good;
   assign hdr_fc    = hdr_ok & beat_data[HDR_FC_BIT];

   // --------------------
   // Status and sticky error
   // --------------------
   always_ff @(posedge clk) begin
      if (ce_corereset) begin
         cpl_status <= '0;
      end else if (hdr_start) begin
         cpl_status <= hdr_status;
      end
   end

   // Cleared only by reset
   always_ff @(posedge clk) begin
      if (ce_corereset) begin
         cpl_err <= 1'b0;
      end else if (hdr_err) begin
         cpl_err <= 1'b1;
      end
   end

endmodule

// ==== ce_rx_pkg.sv ====
// --------------------
// Shared widths and encodings for the completion receive path
// Header is the low 32 bits of the first beat, bits 31:12 are ignored
// FIFO depth must stay a power of two, the pointers wrap freely
// --------------------

package ce_rx_pkg;

   // Bus geometry
   localparam int CE_DATA_W      = 64;
   localparam int CE_KEEP_W      = 8;
   localparam int CE_HALF_W      = 32;
   localparam int CE_HALF_KEEP_W = 4;

   // FIFO entry is {fc, data, keep}
   localparam int CE_CPL_ENTRY_W = 1 + CE_DATA_W + CE_KEEP_W;

   // FIFO sizing
   localparam int CE_FIFO_DEPTH    = 32;
   localparam int CE_FIFO_AW       = $clog2(CE_FIFO_DEPTH);
   localparam int CE_FIFO_CNT_W    = CE_FIFO_AW + 1;
   // Leaves room for two pipeline beats, the flush word and ready latency
   localparam int CE_FIFO_AF_LEVEL = 26;

   // --------------------
   // Completion header fields
   // --------------------
   localparam int HDR_FMT_LSB    = 0;
   localparam int HDR_FMT_W      = 8;
   localparam int HDR_STATUS_LSB = 8;
   localparam int CE_STATUS_W    = 3;
   localparam int HDR_FC_BIT     = 11;

   // Opcodes seen on the receive bus
   typedef enum logic [HDR_FMT_W-1:0] {
      FMT_MEM_RD = 8'h00,
      FMT_MEM_WR = 8'h40,
      FMT_DM_CPL = 8'h4a
   } ce_fmt_e;

   // Receive state machine
   typedef enum logic [1:0] {
      RX_IDLE   = 2'b00,
      RX_CPL_WR = 2'b11
   } ce_rx_state_e;

endpackage

// ==== ce_rx_realign.sv ====
// --------------------
// Shifts payload by half a beat so the header half drops out
// Writes while the FIFO is full are lost, the almost-full margin prevents them
// Flag bit marks the final word of an FC completion only
// --------------------

`timescale 1ns/100ps

module ce_rx_realign import ce_rx_pkg::*; (
   input  logic                      clk,
   input  logic                      ce_corereset,
   input  logic                      wr_active,
   input  logic                      beat_valid,
   input  logic [CE_DATA_W-1:0]      beat_data,
   input  logic [CE_KEEP_W-1:0]      beat_keep,
   input  logic                      beat_last,
   input  logic                      hdr_start,
   input  logic                      hdr_fc,
   input  logic                      fifo_full,
   output logic                      tail_pending,
   output logic                      cpl_wen,
   output logic [CE_CPL_ENTRY_W-1:0] cpl_wdata
);

   logic [CE_HALF_W-1:0]      prev_hi_data;
   logic [CE_HALF_KEEP_W-1:0] prev_hi_keep;
   logic                      last_q;
   logic                      fc_pkt;
   logic                      fc_cur;
   logic                      fc_tail;
   logic                      tail_empty;
   logic                      tail_kept;
   logic [CE_DATA_W-1:0]      word_data;
   logic [CE_KEEP_W-1:0]      word_keep;
   logic                      word_fc;

   // --------------------
   // Held upper half
   // --------------------

   // Captured on every beat, header included
   always_ff @(posedge clk) begin
      if (beat_valid) begin
         prev_hi_data <= beat_data[CE_DATA_W-1:CE_HALF_W];
         prev_hi_keep <= beat_keep[CE_KEEP_W-1:CE_HALF_KEEP_W];
      end
   end

   // Marks the flush cycle after a last beat
   always_ff @(posedge clk) begin
      if (ce_corereset) begin
         last_q <= 1'b0;
      end else begin
         last_q <= beat_last;
      end
   end

   assign tail_pending = last_q;

   // --------------------
   // Final-completion tracking
   // --------------------

   // Fresh header decides, later beats use the held flag
   assign fc_cur = hdr_start ? hdr_fc : fc_pkt;

   always_ff @(posedge clk) begin
      if (ce_corereset) begin
         fc_pkt  <= 1'b0;
         fc_tail <= 1'b0;
      end else begin
         fc_tail <= beat_last & fc_cur;
         if (beat_last) begin
            fc_pkt <= 1'b0;
         end else if (hdr_start) begin
            fc_pkt <= hdr_fc;
         end
      end
   end

   // --------------------
   // Word build and write
   // --------------------

   // Empty upper half on the current last beat means no flush word
   assign tail_empty = (beat_keep[CE_KEEP_W-1:CE_HALF_KEEP_W] == '0);
   assign tail_kept  = (prev_hi_keep != '0);

   always_comb begin
      if (tail_pending) begin
         // Flush word, upper half zero padded
         word_data = {{CE_HALF_W{1'b0}}, prev_hi_data};
         word_keep = {{CE_HALF_KEEP_W{1'b0}}, prev_hi_keep};
         word_fc   = fc_tail;
      end else begin
         word_data = {beat_data[CE_HALF_W-1:0], prev_hi_data};
         word_keep = {beat_keep[CE_HALF_KEEP_W-1:0], prev_hi_keep};
         word_fc   = beat_last & tail_empty & fc_cur;
      end
   end

   // Flush takes the slot even if a new header is registered
   assign cpl_wen   = wr_active & ~fifo_full &
                      (tail_pending ? tail_kept : beat_valid);
   assign cpl_wdata = {word_fc, word_data, word_keep};

endmodule

// ==== ce_rx_top.sv ====
// --------------------
// Completion receive path of the copy engine
// Accepts DM completions only while mrd_start is high
// cpl_err blocks all transfers until reset
// --------------------

`timescale 1ns/100ps

module ce_rx_top import ce_rx_pkg::*; (
   input  logic                      clk,
   input  logic                      ce_corereset,
   input  logic                      rx_tvalid,
   output logic                      rx_tready,
   input  logic [CE_DATA_W-1:0]      rx_tdata,
   input  logic [CE_KEEP_W-1:0]      rx_tkeep,
   input  logic                      rx_tlast,
   input  logic                      mrd_start,
   input  logic                      wr_resp_err,
   input  logic                      fifo_err,
   input  logic                      cpl_rd_en,
   output logic [CE_CPL_ENTRY_W-1:0] cpl_rd_data,
   output logic                      cpl_empty,
   output logic [CE_STATUS_W-1:0]    cpl_status,
   output logic                      cpl_err
);

   // Registered beat
   logic                      beat_valid;
   logic [CE_DATA_W-1:0]      beat_data;
   logic [CE_KEEP_W-1:0]      beat_keep;
   logic                      beat_last;

   // Header decode strobes
   logic                      hdr_start;
   logic                      hdr_ok;
   logic                      hdr_err;
   logic                      hdr_fc;

   // Write path and FIFO flags
   logic                      wr_active;
   logic                      tail_pending;
   logic                      cpl_wen;
   logic [CE_CPL_ENTRY_W-1:0] cpl_wdata;
   logic                      fifo_full;
   logic                      fifo_almost_full;

   ce_rx_ingress i_ce_rx_ingress (
      .clk, .ce_corereset,
      .rx_tvalid, .rx_tdata, .rx_tkeep, .rx_tlast,
      .mrd_start, .fifo_almost_full, .rx_tready,
      .beat_valid, .beat_data, .beat_keep, .beat_last,
      .hdr_start, .hdr_ok, .hdr_err, .hdr_fc,
      .cpl_status, .cpl_err
   );

   ce_rx_fsm i_ce_rx_fsm (
      .clk, .ce_corereset,
      .hdr_start, .hdr_ok, .hdr_err, .beat_last, .tail_pending,
      .wr_resp_err, .fifo_err, .cpl_err,
      .wr_active
   );

   ce_rx_realign i_ce_rx_realign (
      .clk, .ce_corereset,
      .wr_active, .beat_valid, .beat_data, .beat_keep, .beat_last,
      .hdr_start, .hdr_fc, .fifo_full,
      .tail_pending, .cpl_wen, .cpl_wdata
   );

   ce_cpl_fifo i_ce_cpl_fifo (
      .clk, .ce_corereset,
      .cpl_wen, .cpl_wdata, .cpl_rd_en,
      .cpl_rd_data, .cpl_empty, .fifo_full, .fifo_almost_full
   );

endmodule

// ==== sources.f ====
ce_rx_pkg.sv
ce_rx_ingress.sv
ce_rx_fsm.sv
ce_rx_realign.sv
ce_cpl_fifo.sv
ce_rx_top.sv
ce_rx_assert.sv
tb_ce_rx.sv

// ==== tb_ce_rx.sv ====
// --------------------
// Random completion traffic checked against a word-level model
// Four rounds, each opened by a reset and a known good packet
// Bad status is rare, so each round shows traffic both before and after cpl_err
// An aborted packet may write any strict prefix of its words
// --------------------

`timescale 1ns/100ps

module tb_ce_rx import ce_rx_pkg::*; ();

   // About 400 packets of up to 8 beats plus gaps and slow draining
   localparam int TIMEOUT_CYC = 20000;
   localparam int ROUND_PKTS  = 100;

   logic                      clk;
   logic                      ce_corereset;
   logic                      rx_tvalid;
   logic                      rx_tready;
   logic [CE_DATA_W-1:0]      rx_tdata;
   logic [CE_KEEP_W-1:0]      rx_tkeep;
   logic                      rx_tlast;
   logic                      mrd_start;
   logic                      wr_resp_err;
   logic                      fifo_err;
   logic                      cpl_rd_en;
   logic [CE_CPL_ENTRY_W-1:0] cpl_rd_data;
   logic                      cpl_empty;
   logic [CE_STATUS_W-1:0]    cpl_status;
   logic                      cpl_err;

   // Model state, grp_q is nonzero for words of an aborted packet
   logic [CE_CPL_ENTRY_W-1:0] exp_q[$];
   int                        grp_q[$];
   logic [CE_STATUS_W-1:0]    m_status;
   logic                      m_err;
   integer                    seed;
   integer                    drain_seed;
   int                        drain_lvl;
   int                        cycles;
   int                        pkt_cnt;
   string                     test_name;

   ce_rx_top i_ce_rx_top (.*);

   initial clk = 1'b0;
   always #5 clk = ~clk;

   // --------------------
   // Run control
   // --------------------
   task automatic stop_run();
      $display("** FAIL **");
      $fatal(1, "Run stopped at first error");
   endtask

   task automatic report_value(input string what, input logic [CE_CPL_ENTRY_W-1:0] exp_v,
                               input logic [CE_CPL_ENTRY_W-1:0] act_v);
      $display("Fail %s %s: expected %h actual %h", test_name, what, exp_v, act_v);
      stop_run();
   endtask

   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles >= TIMEOUT_CYC) begin
         $display("Timeout after %0d cycles in %s, the DUT stopped moving", cycles, test_name);
         stop_run();
      end
   end

   // Uniform pick from 0 to range-1
   function automatic int pick(input int range);
      return int'($unsigned($random(seed)) % range);
   endfunction

   // --------------------
   // Drain side and word check
   // --------------------
   task automatic check_word(input logic [CE_CPL_ENTRY_W-1:0] got);
      int g;
      // Unwritten rest of an aborted packet is skipped
      while (grp_q.size() > 0 && grp_q[0] != 0 && exp_q[0] != got) begin
         g = grp_q[0];
         while (grp_q.size() > 0 && grp_q[0] == g) begin
            void'(exp_q.pop_front());
            void'(grp_q.pop_front());
         end
      end
      assert (exp_q.size() > 0) else begin
         $display("FIFO returned word %h in %s while no word was expected", got, test_name);
         stop_run();
      end
      assert (exp_q[0] == got) else report_value("word", exp_q[0], got);
      g = grp_q[0];
      void'(exp_q.pop_front());
      void'(grp_q.pop_front());
      // Abort has to cut its packet short
      assert (g == 0 || (grp_q.size() > 0 && grp_q[0] == g)) else begin
         $display("Aborted packet wrote all of its words in %s", test_name);
         stop_run();
      end
   endtask

   // Pop decision and head data both taken mid cycle
   // Drain rate has its own random stream
   always @(posedge clk) begin
      #1;
      cpl_rd_en = (int'($unsigned($random(drain_seed)) % 4) < drain_lvl);
      if (cpl_rd_en && !cpl_empty) begin
         check_word(cpl_rd_data);
      end
   end

   task automatic check_flags();
      assert (cpl_status == m_status) else report_value("cpl_status", m_status, cpl_status);
      assert (cpl_err == m_err) else report_value("cpl_err", m_err, cpl_err);
   endtask

   task automatic do_reset();
      ce_corereset = 1'b1;
      repeat (2) begin
         @(posedge clk);
         #1;
      end
      ce_corereset = 1'b0;
      m_status     = '0;
      m_err        = 1'b0;
   endtask

   // --------------------
   // Packet driver with model update
   // --------------------
   task automatic send_packet(input bit force_good);
      logic [CE_DATA_W-1:0]   d[8];
      logic [CE_KEEP_W-1:0]   k[8];
      ce_fmt_e                fmt;
      logic [CE_STATUS_W-1:0] status;
      logic                   fc;
      logic                   mrd;
      logic                   fe;
      logic                   acc;
      logic                   accepted;
      int                     n;
      int                     i;
      int                     abort_at;
      int                     gap;
      int                     grp;
      pkt_cnt  = pkt_cnt + 1;
      n        = 1 + pick(8);
      fc       = pick(2);
      status   = (pick(50) == 0) ? CE_STATUS_W'(1 + pick(7)) : '0;
      case (pick(8))
         0: fmt = FMT_MEM_RD;
         1: fmt = FMT_MEM_WR;
         default: fmt = FMT_DM_CPL;
      endcase
      mrd      = (pick(8) != 0);
      fe       = (pick(10) == 0);
      // Abort pulse lands strictly inside the packet
      abort_at = (n >= 3 && pick(12) == 0) ? 1 + pick(n - 2) : 0;
      gap      = pick(4);
      if (force_good) begin
         fmt      = FMT_DM_CPL;
         status   = '0;
         mrd      = 1'b1;
         fe       = 1'b0;
         abort_at = 0;
      end
      for (i = 0; i < n; i++) begin
         d[i] = {$random(seed), $random(seed)};
         k[i] = 8'hff;
      end
      // Tail upper half holds 0, 2 or 4 valid bytes
      case (pick(3))
         0: k[n-1] = 8'h0f;
         1: k[n-1] = 8'h3f;
         default: k[n-1] = 8'hff;
      endcase
      // Header in the low half, tag bits stay random
      d[0][31:0] = {d[0][31:12], fc, status, fmt};

      // Only DM completions during a read touch status and error
      accepted = 1'b0;
      if (fmt == FMT_DM_CPL && mrd) begin
         accepted = (status == '0) && !m_err && !fe;
         m_status = status;
         if (status != '0) begin
            m_err = 1'b1;
         end
      end
      grp = (abort_at != 0) ? pkt_cnt : 0;
      if (accepted) begin
         // Word k is {beat k low half, beat k-1 high half}
         for (i = 1; i < n; i++) begin
            exp_q.push_back({fc && (i == n - 1) && (k[n-1][7:4] == 4'h0),
                             d[i][31:0], d[i-1][63:32], k[i][3:0], k[i-1][7:4]});
            grp_q.push_back(grp);
         end
         // Flush word carries the tail half
         if (k[n-1][7:4] != 4'h0) begin
            exp_q.push_back({fc, 32'h0, d[n-1][63:32], 4'h0, k[n-1][7:4]});
            grp_q.push_back(grp);
         end
      end

      mrd_start = mrd;
      fifo_err  = fe;
      for (i = 0; i < n; i++) begin
         rx_tvalid   = 1'b1;
         rx_tdata    = d[i];
         rx_tkeep    = k[i];
         rx_tlast    = (i == n - 1);
         wr_resp_err = (abort_at != 0) && (i == abort_at);
         // Beat held until ready is seen before an edge
         acc = 1'b0;
         while (!acc) begin
            acc = rx_tready;
            @(posedge clk);
            #1;
            wr_resp_err = 1'b0;
         end
      end
      rx_tvalid = 1'b0;
      rx_tlast  = 1'b0;
      // Decode reads mrd_start and fifo_err in the cycle after the header
      if (n == 1 && gap == 0) begin
         gap = 1;
      end
      repeat (gap) begin
         @(posedge clk);
         #1;
      end
      // Status registers settle one cycle after the header
      if (gap > 0) begin
         check_flags();
      end
   endtask

   task automatic run_round(input string name, input int drain);
      test_name = name;
      drain_lvl = drain;
      do_reset();
      check_flags();
      send_packet(1'b1);
      repeat (ROUND_PKTS - 1) send_packet(1'b0);
      // Last flush word lands within the pipeline depth
      repeat (4) begin
         @(posedge clk);
         #1;
      end
      while (!cpl_empty) begin
         @(posedge clk);
         #1;
      end
      while (grp_q.size() > 0 && grp_q[0] != 0) begin
         void'(exp_q.pop_front());
         void'(grp_q.pop_front());
      end
      assert (exp_q.size() == 0) else begin
         $display("FIFO ran empty in %s with %0d words still expected", name, exp_q.size());
         stop_run();
      end
      check_flags();
   endtask

   initial begin
      seed         = 32'hcd0672af;
      drain_seed   = seed;
      cycles       = 0;
      pkt_cnt      = 0;
      drain_lvl    = 4;
      test_name    = "reset";
      ce_corereset = 1'b1;
      rx_tvalid    = 1'b0;
      rx_tdata     = '0;
      rx_tkeep     = '0;
      rx_tlast     = 1'b0;
      mrd_start    = 1'b0;
      wr_resp_err  = 1'b0;
      fifo_err     = 1'b0;
      cpl_rd_en    = 1'b0;
      m_status     = '0;
      m_err        = 1'b0;
      run_round("fast_drain", 3);
      run_round("slow_drain", 1);
      run_round("full_drain", 4);
      run_round("stall_drain", 1);
      $display("** PASS **");
      $finish;
   end

endmodule
